// File: include/div_defs.svh
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// datapath width.
`define DIV_XLEN 32

// physical register tags.
`define DIV_TAG_W 6
`define DIV_NUM_PREGS 64

// reservation station depth and the index width that covers it.
`define DIV_RS_DEPTH 8
`define DIV_IDX_W 3

`endif

// File: design/div_pkg.sv
`include "div_defs.svh"

package div_pkg;

  // riscv M-extension divide family.
  typedef enum logic [1:0] {
    DIV  = 2'd0,
    DIVU = 2'd1,
    REM  = 2'd2,
    REMU = 2'd3
  } div_op_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    FIX  = 2'd2  // sign and special-case correction.
  } div_state_e;

  // micro-op as it arrives from rename.
  typedef struct packed {
    div_op_e               op;
    logic [`DIV_TAG_W-1:0] dst_tag;
    logic [`DIV_TAG_W-1:0] src1_tag;
    logic                  src1_ready;
    logic [`DIV_TAG_W-1:0] src2_tag;
    logic                  src2_ready;
  } div_dispatch_t;

  // selected entry whose operands come from the register slice.
  typedef struct packed {
    div_op_e               op;
    logic [`DIV_TAG_W-1:0] dst_tag;
    logic [`DIV_TAG_W-1:0] src1_tag;
    logic [`DIV_TAG_W-1:0] src2_tag;
  } div_issue_t;

  // completion broadcast that doubles as a register write.
  typedef struct packed {
    logic                  valid;
    logic [`DIV_TAG_W-1:0] tag;
    logic [`DIV_XLEN-1:0]  data;
  } div_wb_t;

endpackage

// File: design/div_rs.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_rs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  logic                   dispatch_valid,
  input  div_pkg::div_dispatch_t dispatch,
  input  div_pkg::div_wb_t       ext_wb,
  input  div_pkg::div_wb_t       div_wb,
  input  logic                   busy,
  output logic                   issue_valid,
  output div_pkg::div_issue_t    issue,
  output logic                   rs_full
);
  import div_pkg::*;

  localparam int DEPTH = `DIV_RS_DEPTH;
  localparam int IDX_W = `DIV_IDX_W;

  div_dispatch_t    ent_q [DEPTH];
  logic [DEPTH-1:0] valid_q;
  logic [DEPTH-1:0] valid_d;
  logic [DEPTH-1:0] ready_vec;
  logic [IDX_W-1:0] alloc_idx;
  logic [IDX_W-1:0] sel_idx;
  logic             alloc_ok;
  logic             sel_ok;
  logic             do_alloc;
  logic             rs_full_q;

  // true when either broadcast carries this tag.
  function automatic logic woken(input logic [`DIV_TAG_W-1:0] tag);
    return (ext_wb.valid && ext_wb.tag == tag) || (div_wb.valid && div_wb.tag == tag);
  endfunction

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      ready_vec[i] = valid_q[i] && ent_q[i].src1_ready && ent_q[i].src2_ready;
    end
  end

  // lowest free slot.
  always_comb begin
    alloc_ok  = 1'b0;
    alloc_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        alloc_ok  = 1'b1;
        alloc_idx = IDX_W'(i);
      end
    end
  end

  // lowest ready entry wins.
  always_comb begin
    sel_ok  = 1'b0;
    sel_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (ready_vec[i]) begin
        sel_ok  = 1'b1;
        sel_idx = IDX_W'(i);
      end
    end
  end

  assign do_alloc    = dispatch_valid && alloc_ok;  // a dispatch into a full station is lost.
  assign issue_valid = sel_ok && !busy;

  always_comb begin
    issue.op       = ent_q[sel_idx].op;
    issue.dst_tag  = ent_q[sel_idx].dst_tag;
    issue.src1_tag = ent_q[sel_idx].src1_tag;
    issue.src2_tag = ent_q[sel_idx].src2_tag;
  end

  // occupancy after this edge.
  always_comb begin
    valid_d = valid_q;
    if (issue_valid) begin
      valid_d[sel_idx] = 1'b0;
    end
    if (do_alloc) begin
      valid_d[alloc_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid_q   <= '0;
      rs_full_q <= 1'b0;
    end else begin
      valid_q   <= valid_d;
      rs_full_q <= &valid_d;
    end
  end

  // entry payload and wakeup.
  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (do_alloc && int'(alloc_idx) == i) begin
        ent_q[i]            <= dispatch;
        // same-cycle bypass from either broadcast.
        ent_q[i].src1_ready <= dispatch.src1_ready || woken(dispatch.src1_tag);
        ent_q[i].src2_ready <= dispatch.src2_ready || woken(dispatch.src2_tag);
      end else begin
        if (woken(ent_q[i].src1_tag)) begin
          ent_q[i].src1_ready <= 1'b1;
        end
        if (woken(ent_q[i].src2_tag)) begin
          ent_q[i].src2_ready <= 1'b1;
        end
      end
    end
  end

  assign rs_full = rs_full_q;

endmodule

// File: design/div_prf.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_prf (
  input  logic                  clk,
  input  logic                  rst_n,
  input  div_pkg::div_wb_t      ext_wb,
  input  div_pkg::div_wb_t      div_wb,
  input  logic [`DIV_TAG_W-1:0] rd_tag1,
  input  logic [`DIV_TAG_W-1:0] rd_tag2,
  output logic [`DIV_XLEN-1:0]  rd_data1,
  output logic [`DIV_XLEN-1:0]  rd_data2
);

  localparam int XLEN    = `DIV_XLEN;
  localparam int NUM_REG = `DIV_NUM_PREGS;

  logic [XLEN-1:0] regs_q [NUM_REG];

  // read that forwards this cycle's writes with the external port first.
  function automatic logic [XLEN-1:0] rd_fwd(input logic [`DIV_TAG_W-1:0] tag);
    logic [XLEN-1:0] val;
    val = regs_q[tag];
    if (ext_wb.valid && ext_wb.tag == tag) begin
      val = ext_wb.data;
    end else if (div_wb.valid && div_wb.tag == tag) begin
      val = div_wb.data;
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REG; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (div_wb.valid) begin
        regs_q[div_wb.tag] <= div_wb.data;
      end
      // later assignment wins a same-tag collision.
      if (ext_wb.valid) begin
        regs_q[ext_wb.tag] <= ext_wb.data;
      end
    end
  end

  always_comb begin
    rd_data1 = rd_fwd(rd_tag1);
    rd_data2 = rd_fwd(rd_tag2);
  end

endmodule

// File: design/div_unit.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 issue_valid,
  input  div_pkg::div_issue_t  issue,
  input  logic [`DIV_XLEN-1:0] src1_data,
  input  logic [`DIV_XLEN-1:0] src2_data,
  output logic                 busy,
  output div_pkg::div_wb_t     div_wb
);
  import div_pkg::*;

  localparam int XLEN  = `DIV_XLEN;
  localparam int CNT_W = $clog2(XLEN);

  div_state_e            state_q;
  logic [CNT_W-1:0]      count_q;
  logic                  wb_valid_q;
  logic [XLEN-1:0]       wb_data_q;

  div_op_e               op_q;
  logic [`DIV_TAG_W-1:0] tag_q;
  logic [XLEN-1:0]       dividend_q;  // original value needed for the special cases.
  logic [XLEN-1:0]       dvs_q;
  logic [XLEN-1:0]       quo_q;
  logic [XLEN-1:0]       rem_q;
  logic                  neg_quo_q;
  logic                  neg_rem_q;
  logic                  zero_q;
  logic                  ovf_q;

  logic                  is_signed;
  logic                  a_neg;
  logic                  b_neg;
  logic [XLEN:0]         shifted;
  logic [XLEN:0]         diff;
  logic [XLEN-1:0]       quo_fix;
  logic [XLEN-1:0]       rem_fix;

  assign is_signed = (issue.op == DIV) || (issue.op == REM);
  assign a_neg     = is_signed && src1_data[XLEN-1];
  assign b_neg     = is_signed && src2_data[XLEN-1];

  // one restoring step.
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign diff    = shifted - {1'b0, dvs_q};

  always_comb begin
    quo_fix = neg_quo_q ? -quo_q : quo_q;
    rem_fix = neg_rem_q ? -rem_q : rem_q;
    if (zero_q) begin
      quo_fix = '1;
      rem_fix = dividend_q;
    end else if (ovf_q) begin
      quo_fix = dividend_q;  // most negative / -1.
      rem_fix = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      state_q    <= IDLE;
      count_q    <= '0;
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (issue_valid) begin
            state_q <= RUN;
            count_q <= '0;
          end
        end
        RUN: begin
          count_q <= count_q + 1'b1;
          if (count_q == CNT_W'(XLEN - 1)) begin
            state_q <= FIX;
          end
        end
        FIX: begin
          state_q    <= IDLE;
          wb_valid_q <= 1'b1;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state_q)
      IDLE: begin
        if (issue_valid) begin
          op_q       <= issue.op;
          tag_q      <= issue.dst_tag;
          dividend_q <= src1_data;
          quo_q      <= a_neg ? -src1_data : src1_data;  // magnitudes.
          dvs_q      <= b_neg ? -src2_data : src2_data;
          rem_q      <= '0;
          neg_quo_q  <= a_neg ^ b_neg;
          neg_rem_q  <= a_neg;
          zero_q     <= (src2_data == '0);
          ovf_q      <= is_signed && (src1_data == {1'b1, {(XLEN-1){1'b0}}})
                        && (src2_data == '1);
        end
      end
      RUN: begin
        if (!diff[XLEN]) begin
          rem_q <= diff[XLEN-1:0];
          quo_q <= {quo_q[XLEN-2:0], 1'b1};
        end else begin
          rem_q <= shifted[XLEN-1:0];
          quo_q <= {quo_q[XLEN-2:0], 1'b0};
        end
      end
      FIX: wb_data_q <= (op_q == DIV || op_q == DIVU) ? quo_fix : rem_fix;
      default: ;
    endcase
  end

  assign busy = (state_q != IDLE);

  // tag_q holds until the next latch, which is no earlier than the result cycle.
  assign div_wb = '{valid: wb_valid_q, tag: tag_q, data: wb_data_q};

endmodule

// File: design/div_cluster.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_cluster (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dispatch_valid,
  input  div_pkg::div_dispatch_t dispatch,
  input  div_pkg::div_wb_t       ext_wb,
  input  logic                   flush,
  output div_pkg::div_wb_t       div_wb,
  output logic                   rs_full
);
  import div_pkg::*;

  logic                 issue_valid;
  div_issue_t           issue;
  logic                 busy;
  logic [`DIV_XLEN-1:0] src1_data;
  logic [`DIV_XLEN-1:0] src2_data;

  div_rs rs_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .ext_wb         (ext_wb),
    .div_wb         (div_wb),  // own results wake dependents.
    .busy           (busy),
    .issue_valid    (issue_valid),
    .issue          (issue),
    .rs_full        (rs_full)
  );

  // operand read happens in the issue cycle.
  div_prf prf_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ext_wb   (ext_wb),
    .div_wb   (div_wb),
    .rd_tag1  (issue.src1_tag),
    .rd_tag2  (issue.src2_tag),
    .rd_data1 (src1_data),
    .rd_data2 (src2_data)
  );

  div_unit unit_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue       (issue),
    .src1_data   (src1_data),
    .src2_data   (src2_data),
    .busy        (busy),
    .div_wb      (div_wb)
  );

endmodule

// File: dv/div_cluster_props.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_cluster_props (
  input logic             clk,
  input logic             rst_n,
  input logic             flush,
  input logic             dispatch_valid,
  input logic             rs_full,
  input logic             issue_valid,
  input logic             busy,
  input div_pkg::div_wb_t div_wb
);

  a_no_dispatch_full: assert property (@(posedge clk) disable iff (!rst_n)
    dispatch_valid |-> !rs_full) else $error("dispatch while station full");

  // an issued op occupies the divider from the next cycle on.
  a_issue_taken: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid && !flush |=> busy) else $error("divider did not take the issued op");

  // the iterative divider spaces its results apart.
  a_no_b2b: assert property (@(posedge clk) disable iff (!rst_n)
    div_wb.valid |=> !div_wb.valid) else $error("back to back results");

  a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !div_wb.valid) else $error("result right after flush");

endmodule

bind div_cluster div_cluster_props props_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .flush          (flush),
  .dispatch_valid (dispatch_valid),
  .rs_full        (rs_full),
  .issue_valid    (issue_valid),
  .busy           (busy),
  .div_wb         (div_wb)
);

// File: dv/div_cluster_tb.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_cluster_tb;
  import div_pkg::*;

  typedef struct packed {
    div_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic        late;  // operands arrive after dispatch.
  } row_t;

  localparam int NUM_ROWS = 16;
  localparam int NUM_OPS  = NUM_ROWS + 8 + 2 + 3;

  row_t table_q [NUM_ROWS] = '{
    '{DIV,  32'd20,        32'd6,         32'd3,         1'b0},
    '{DIV,  32'hffffffec,  32'd6,         32'hfffffffd,  1'b0},
    '{REM,  32'hffffffec,  32'd6,         32'hfffffffe,  1'b0},
    '{REM,  32'd20,        32'hfffffffa,  32'd2,         1'b1},
    '{DIVU, 32'hffffffff,  32'd3,         32'h55555555,  1'b0},
    '{REMU, 32'd100,       32'd7,         32'd2,         1'b1},
    '{DIV,  32'd1234,      32'd0,         32'hffffffff,  1'b0},
    '{REM,  32'd7,         32'd0,         32'd7,         1'b0},
    '{DIVU, 32'd5,         32'd0,         32'hffffffff,  1'b0},
    '{REMU, 32'h80000000,  32'd0,         32'h80000000,  1'b0},
    '{DIV,  32'h80000000,  32'hffffffff,  32'h80000000,  1'b0},
    '{REM,  32'h80000000,  32'hffffffff,  32'd0,         1'b1},
    '{DIVU, 32'h80000000,  32'hffffffff,  32'd0,         1'b0},
    '{REMU, 32'h80000000,  32'hffffffff,  32'h80000000,  1'b0},
    '{DIV,  32'hfffffff9,  32'hfffffffe,  32'd3,         1'b0},
    '{REM,  32'hfffffff9,  32'hfffffffe,  32'hffffffff,  1'b0}
  };

  logic          clk = 1'b0;
  logic          rst_n;
  logic          dispatch_valid;
  div_dispatch_t dispatch;
  div_wb_t       ext_wb;
  logic          flush;
  div_wb_t       div_wb;
  logic          rs_full;

  logic [31:0]          sb [int];  // expected value by destination tag.
  logic [`DIV_TAG_W-1:0] next_tag = '0;
  logic [31:0]          lfsr_q = 32'hfee1_2c74;

  div_cluster dut_i (.*);

  always #10 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("ERROR @%0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "check failed");
  endtask

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[30:0], lfsr_q[0]};
    end
  endtask

  // riscv M-extension divide rules.
  function automatic logic [31:0] expect_of(input div_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic is_div;
    is_div = (op == DIV) || (op == DIVU);
    if (b == 0) return is_div ? 32'hffffffff : a;
    if ((op == DIV || op == REM) && a == 32'h80000000 && b == 32'hffffffff)
      return is_div ? a : 32'd0;
    case (op)
      DIV:     return $signed(a) / $signed(b);
      REM:     return $signed(a) % $signed(b);
      DIVU:    return a / b;
      default: return a % b;
    endcase
  endfunction

  function automatic logic [`DIV_TAG_W-1:0] new_tag();
    next_tag = next_tag + 1'b1;
    return next_tag;
  endfunction

  task automatic write_reg(input logic [`DIV_TAG_W-1:0] tag, input logic [31:0] data);
    @(posedge clk);
    ext_wb <= '{valid: 1'b1, tag: tag, data: data};
    @(posedge clk);
    ext_wb.valid <= 1'b0;
  endtask

  task automatic send_uop(input div_op_e op, input logic [`DIV_TAG_W-1:0] dst,
                          input logic [`DIV_TAG_W-1:0] s1, input logic r1,
                          input logic [`DIV_TAG_W-1:0] s2, input logic r2);
    @(posedge clk);
    dispatch_valid <= 1'b1;
    dispatch       <= '{op: op, dst_tag: dst, src1_tag: s1, src1_ready: r1,
                        src2_tag: s2, src2_ready: r2};
    @(posedge clk);
    dispatch_valid <= 1'b0;
  endtask

  // wait for the outstanding results within the divide latency of each.
  task automatic drain();
    int limit;
    limit = sb.num() * 40 + 40;
    while (sb.num() != 0 && limit > 0) begin
      @(posedge clk);
      limit--;
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic run_row(input row_t r);
    logic [`DIV_TAG_W-1:0] t1, t2, d;
    t1 = new_tag();
    t2 = new_tag();
    d  = new_tag();
    if (!r.late) begin
      write_reg(t1, r.a);
      write_reg(t2, r.b);
    end
    send_uop(r.op, d, t1, !r.late, t2, !r.late);
    if (r.late) begin
      repeat (40) @(posedge clk);  // nothing may complete while sources are missing.
      sb[d] = r.exp;
      write_reg(t2, r.b);
      write_reg(t1, r.a);
    end else begin
      sb[d] = r.exp;
    end
    drain();
  endtask

  always @(negedge clk) begin
    if (rst_n && div_wb.valid) begin
      assert (sb.exists(int'(div_wb.tag)))
        else fail_now($sformatf("result on unexpected tag %0d", div_wb.tag));
      assert (sb[int'(div_wb.tag)] == div_wb.data)
        else fail_now($sformatf("tag %0d got %h expected %h", div_wb.tag, div_wb.data,
                                sb[int'(div_wb.tag)]));
      sb.delete(int'(div_wb.tag));
    end
  end

  initial begin
    repeat (NUM_OPS * 120 + 2000) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  end

  initial begin
    logic [`DIV_TAG_W-1:0] ta, tb, tc, d1, d2;
    logic [`DIV_TAG_W-1:0] fa [8];
    logic [`DIV_TAG_W-1:0] fd [8];
    logic [31:0]           fv [8];
    logic [31:0]           w;
    div_op_e               fop;
    rst_n = 1'b0;
    flush = 1'b0;
    dispatch_valid = 1'b0;
    dispatch = '0;
    ext_wb = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    foreach (table_q[i]) run_row(table_q[i]);

    // the second divide of the chain waits on the first result.
    ta = new_tag();
    tb = new_tag();
    tc = new_tag();
    d1 = new_tag();
    d2 = new_tag();
    write_reg(ta, 32'd1000);
    write_reg(tb, 32'd7);
    write_reg(tc, 32'd9);
    sb[d1] = 32'd142;
    sb[d2] = 32'd7;
    send_uop(DIVU, d1, ta, 1'b1, tb, 1'b1);
    send_uop(REMU, d2, d1, 1'b0, tc, 1'b1);
    drain();

    // fill the station with entries whose dividend is missing.
    for (int i = 0; i < 8; i++) begin
      fa[i] = new_tag();
      tb    = new_tag();
      fd[i] = new_tag();
      rand_word(fv[i]);
      rand_word(w);
      w   = w >> (i * 3);
      fop = div_op_e'(i % 4);
      sb[fd[i]] = expect_of(fop, fv[i], w);
      write_reg(tb, w);
      send_uop(fop, fd[i], fa[i], 1'b0, tb, 1'b1);
    end
    @(negedge clk);
    assert (rs_full) else fail_now("station not full after eight dispatches");
    for (int i = 0; i < 8; i++) write_reg(fa[i], fv[i]);
    drain();

    // flush with a divide running and an entry waiting.
    ta = new_tag();
    tb = new_tag();
    write_reg(ta, 32'd77);
    write_reg(tb, 32'd5);
    send_uop(DIV, new_tag(), ta, 1'b1, tb, 1'b1);
    repeat (10) @(posedge clk);
    send_uop(REM, new_tag(), new_tag(), 1'b0, tb, 1'b1);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    repeat (60) @(posedge clk);
    run_row('{DIV, 32'hffffff9c, 32'd7, 32'hfffffff2, 1'b0});

    assert (dut_i.unit_i.state_q == IDLE) else fail_now("divider not idle at end");
    if (sb.num() != 0) begin
      $display("%0d expected results never arrived", sb.num());
      $display("ERRORS FOUND");
      $fatal(1, "missing results");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// File: project.f
+incdir+include
design/div_pkg.sv
design/div_rs.sv
design/div_prf.sv
design/div_unit.sv
design/div_cluster.sv
dv/div_cluster_props.sv
dv/div_cluster_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module div_cluster_tb \
  -o div_cluster_sim &&
./obj_dir/div_cluster_sim || exit 1
